// ==== dv/portalTb.sv ====
`timescale 1ns/100ps

module portalTb;
  import portalPkg::*;

  localparam int waitLimit = 2000;
  localparam logic [31:0] dataAddr = 32'h0000_0020;   // Bit 5 set, data region

  logic CLK, RST_N;
  logic arValid, arReady, rValid, rReady, awValid, awReady;
  logic wValid, wLast, wReady, bValid, bReady;
  logic reqValid, reqReady, indValid, indReady, irq;
  logic [31:0] wData;
  addrChanT ar, aw;
  rDataT r;
  bRespT b;
  msgT reqMsg, indMsg;

  rDataT rSeen[$];
  bRespT bSeen[$];
  msgT reqSeen[$];
  int errors, checks, testBase, tests, failedTests;
  integer seed, readySeed;
  logic shakeReady, irqEnabled;
  idT id;
  // Status, filler, tiles, queue status, portal id, portal count
  logic [31:0] ctrlExpect [6] = '{32'd0, 32'h005A_05A0, 32'd1, 32'd0, 32'd6, 32'd2};

  portalTop #(.fifoDepth(2), .msgWords(4)) uut (.*);

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    if (shakeReady) begin
      rReady   <= 1'($random(readySeed));
      bReady   <= 1'($random(readySeed));
      reqReady <= 1'($random(readySeed));
    end else begin
      rReady   <= 1'b1;
      bReady   <= 1'b1;
      reqReady <= 1'b1;
    end
  end

  // Transfers seen here complete on the next rising edge
  always @(negedge CLK) begin
    if (RST_N && rValid && rReady) rSeen.push_back(r);
    if (RST_N && bValid && bReady) bSeen.push_back(b);
    if (RST_N && reqValid && reqReady) reqSeen.push_back(reqMsg);
  end

  rHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    rValid && !rReady |=> rValid && $stable(r))
    else begin
      errors++;
      $display("mismatch at %0t ns: R beat changed before its transfer", $time);
    end
  bHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    bValid && !bReady |=> bValid && $stable(b))
    else begin
      errors++;
      $display("mismatch at %0t ns: B response changed before its transfer", $time);
    end
  reqHeld: assert property (@(posedge CLK) disable iff (!RST_N)
    reqValid && !reqReady |=> reqValid && $stable(reqMsg))
    else begin
      errors++;
      $display("mismatch at %0t ns: request message changed before its transfer", $time);
    end
  irqCause: assert property (@(posedge CLK) disable iff (!RST_N)
    irq |-> irqEnabled && !indReady)
    else begin
      errors++;
      $display("mismatch at %0t ns: irq high without enable and pending words", $time);
    end

  task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic timedOut(input string what);
    $display("timeout at %0t ns waiting for %s", $time, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic endTest(input string name);
    tests++;
    if (errors == testBase) begin
      $display("test %s: pass", name);
    end else begin
      failedTests++;
      $display("test %s: fail, %0d errors", name, errors - testBase);
    end
    testBase = errors;
  endtask

  function automatic int seenCount(input int which);
    case (which)
      0: return rSeen.size();
      1: return bSeen.size();
      default: return reqSeen.size();
    endcase
  endfunction

  task automatic waitSeen(input int which, input int target, input string what);
    int cycles;
    cycles = 0;
    while (seenCount(which) < target) begin
      @(posedge CLK);
      cycles++;
      if (cycles > waitLimit) timedOut(what);
    end
  endtask

  task automatic sendAddr(input logic write, input logic [31:0] addr, input idT tid,
                          input logic [3:0] len);
    addrChanT req;
    int cycles;
    req.addr = addr;
    req.id = tid;
    req.len = len;
    cycles = 0;
    if (write) begin
      awValid <= 1'b1;
      aw <= req;
    end else begin
      arValid <= 1'b1;
      ar <= req;
    end
    do begin
      @(posedge CLK);
      cycles++;
      if (cycles > waitLimit) timedOut(write ? "write address accept" : "read address accept");
    end while (!(write ? awReady : arReady));
    if (write) awValid <= 1'b0;
    else arValid <= 1'b0;
  endtask

  task automatic writeWord(input logic [31:0] addr, input idT tid, input logic [31:0] word);
    int cycles, bBase;
    bBase = bSeen.size();
    cycles = 0;
    sendAddr(1'b1, addr, tid, 4'd0);
    wValid <= 1'b1;
    wData <= word;
    wLast <= 1'b1;
    do begin
      @(posedge CLK);
      cycles++;
      if (cycles > waitLimit) timedOut("write data accept");
    end while (!wReady);
    wValid <= 1'b0;
    wLast <= 1'b0;
    waitSeen(1, bBase + 1, "write response");
    expectEq("write response id", bSeen[bBase].id, tid);
  endtask

  task automatic readBurst(input logic [31:0] addr, input idT tid, input int beats);
    rSeen.delete();
    sendAddr(1'b0, addr, tid, 4'(beats - 1));
    waitSeen(0, beats, "read data");
    foreach (rSeen[i]) begin
      expectEq("read id", rSeen[i].id, tid);
      expectEq("read last", rSeen[i].last, i == beats - 1);
    end
  endtask

  task automatic readWord(input logic [31:0] addr, output logic [31:0] data);
    readBurst(addr, 6'($random(seed)), 1);
    data = rSeen[0].data;
  endtask

  task automatic sendIndication(input msgT msg);
    int cycles;
    cycles = 0;
    indValid <= 1'b1;
    indMsg <= msg;
    do begin
      @(posedge CLK);
      cycles++;
      if (cycles > waitLimit) timedOut("indication accept");
    end while (!indReady);
    indValid <= 1'b0;
  endtask

  task automatic requestAssembly();
    logic [31:0] words [4];
    idT ids [4];
    int i, bBase, reqBase;
    bBase = bSeen.size();
    reqBase = reqSeen.size();
    for (i = 0; i < 4; i++) begin
      words[i] = $random(seed);
      ids[i] = 6'($random(seed));
    end
    for (i = 0; i < 3; i++) writeWord(dataAddr, ids[i], words[i]);
    expectEq("messages before completing write", reqSeen.size() - reqBase, 0);
    writeWord(dataAddr + 32'd4, ids[3], words[3]);
    waitSeen(2, reqBase + 1, "request message");
    for (i = 0; i < 4; i++) expectEq("request word", reqSeen[reqBase][3 - i], words[i]);
    expectEq("write responses", bSeen.size() - bBase, 4);
    expectEq("request messages", reqSeen.size() - reqBase, 1);
  endtask

  task automatic indicationDrain(input int count, input logic expectIrq);
    msgT msg;
    logic [31:0] got;
    int k;
    msg[0] = {16'($random(seed)), 16'(count)};   // Word count in the low half
    for (k = 1; k < 4; k++) msg[k] = $random(seed);
    expectEq("indReady before message", indReady, 1'b1);
    sendIndication(msg);
    @(posedge CLK);   // Count loads on the accepting edge
    expectEq("indReady while pending", indReady, 1'b0);
    expectEq("irq while pending", irq, expectIrq);
    readWord(32'h0000_0000, got);
    expectEq("interrupt status", got, 32'd1);
    for (k = 0; k < count; k++) begin
      readWord(32'h0000_000C, got);
      expectEq("queue status", got, count - k);
      readWord(dataAddr, got);
      expectEq("indication word", got, msg[k]);
    end
    readWord(32'h0000_000C, got);
    expectEq("queue status after drain", got, 0);
    expectEq("indReady after drain", indReady, 1'b1);
    expectEq("irq after drain", irq, 1'b0);
  endtask

  initial begin
    CLK = 1'b0;
    RST_N = 1'b0;
    {arValid, awValid, wValid, wLast, indValid} = '0;
    {rReady, bReady, reqReady} = 3'b111;
    ar = '0;
    aw = '0;
    wData = '0;
    indMsg = '0;
    shakeReady = 1'b0;
    irqEnabled = 1'b0;
    seed = 32'h1f38;
    readySeed = 32'h1f38;    // Separate stream for the ready toggling
    {errors, checks, testBase, tests, failedTests} = '0;
    repeat (16) @(posedge CLK);
    RST_N <= 1'b1;

    expectEq("rValid", rValid, 1'b0);
    expectEq("bValid", bValid, 1'b0);
    expectEq("reqValid", reqValid, 1'b0);
    expectEq("irq", irq, 1'b0);
    expectEq("indReady", indReady, 1'b1);
    endTest("reset values");

    id = 6'($random(seed));
    readBurst(32'h0000_1000, id, 6);   // Portal bit set
    foreach (ctrlExpect[i]) expectEq("control register", rSeen[i].data, ctrlExpect[i]);
    endTest("control register burst");

    requestAssembly();
    endTest("request assembly");

    indicationDrain(3, 1'b0);
    endTest("indication drain");

    writeWord(32'h0000_0004, 6'($random(seed)), 32'd1);
    irqEnabled = 1'b1;
    expectEq("irq with nothing pending", irq, 1'b0);
    indicationDrain(2, 1'b1);
    endTest("interrupt");

    shakeReady = 1'b1;
    requestAssembly();
    indicationDrain(3, 1'b1);
    shakeReady = 1'b0;
    endTest("back-pressure");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failedTests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/burstExpander.sv ====
`timescale 1ns/100ps

module burstExpander #(
  parameter int fifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                reqValid,
  input  portalPkg::addrChanT req,
  output logic                reqReady,
  output logic                beatValid,
  output portalPkg::beatT     beat,
  input  logic                beatReady
);
  import portalPkg::*;

  addrChanT head;
  logic headValid, headPop, load;
  logic active;               // A burst is being expanded
  logic [4:0] offset;
  logic [3:0] remain;
  logic isCtrl, portalSel;

  syncFifo #(.fifoDepth(fifoDepth), .width($bits(addrChanT))) reqFifo (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (reqValid),
    .inData   (req),
    .inReady  (reqReady),
    .outValid (headValid),
    .outData  (head),
    .outReady (headPop)
  );

  assign load      = !active && headValid;
  assign beatValid = active;
  assign beat      = '{offset: offset, id: head.id, last: remain == 4'd0,
                       isCtrl: isCtrl, portalSel: portalSel};
  assign headPop   = beatValid && beatReady && beat.last;

  always_ff @(posedge CLK) begin
    if (!RST_N) active <= 1'b0;
    else if (load) active <= 1'b1;
    else if (headPop) active <= 1'b0;
  end

  // Region decode happens once, on load
  always_ff @(posedge CLK) begin
    if (load) begin
      offset    <= head.addr[4:0];
      remain    <= head.len;
      isCtrl    <= (head.addr & ctrlRegionBits) == '0;
      portalSel <= head.addr[portalSelBit];
    end else if (beatValid && beatReady) begin
      offset <= offset + 5'd4;  // Four bytes per beat
      remain <= remain - 4'd1;
    end
  end

endmodule

// ==== rtl/messageBuffers.sv ====
`timescale 1ns/100ps

module messageBuffers #(
  parameter int msgWords = 4
) (
  input  logic           CLK,
  input  logic           RST_N,
  input  logic           push,
  input  logic [31:0]    pushWord,
  input  logic           complete,
  output logic           reqValid,
  output portalPkg::msgT reqMsg,
  input  logic           reqReady,
  output logic           reqNotFull,
  input  logic           indValid,
  input  portalPkg::msgT indMsg,
  output logic           indReady,
  input  logic           drain,
  output logic [31:0]    indWord,
  output logic [15:0]    indRemain
);
  logic [msgWords-2:0][31:0] reqHist;   // Newest word lowest
  logic [msgWords-1:0][31:0] indBuf;
  logic indLoad;

  // Single slot, refilled only while the core is taking the current one
  assign reqNotFull = reqReady;

  always_ff @(posedge CLK) begin
    if (!RST_N) reqValid <= 1'b0;
    else if (push && complete) reqValid <= 1'b1;
    else if (reqReady) reqValid <= 1'b0;
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      reqHist <= {reqHist[msgWords-3:0], pushWord};
      if (complete) reqMsg <= {reqHist, pushWord};  // Oldest word on top
    end
  end

  assign indReady = indRemain == 16'd0;
  assign indLoad  = indValid && indReady;
  assign indWord  = indBuf[0];

  always_ff @(posedge CLK) begin
    if (!RST_N) indRemain <= '0;
    else if (indLoad) indRemain <= indMsg[0][15:0];  // Count rides in the low half
    else if (drain) indRemain <= indRemain - 16'd1;
  end

  always_ff @(posedge CLK) begin
    if (indLoad) indBuf <= indMsg;
    else if (drain) indBuf <= {32'd0, indBuf[msgWords-1:1]};
  end

endmodule

// ==== rtl/portalPkg.sv ====
package portalPkg;

  typedef logic [5:0] idT;

  typedef struct packed {
    logic [31:0] addr;
    idT          id;
    logic [3:0]  len;       // Beats minus one
  } addrChanT;

  typedef struct packed {
    logic [4:0] offset;
    idT         id;
    logic       last;
    logic       isCtrl;
    logic       portalSel;
  } beatT;

  typedef struct packed {
    logic [31:0] data;
    idT          id;
    logic        last;
  } rDataT;

  typedef struct packed {
    idT id;
  } bRespT;

  typedef logic [3:0][31:0] msgT;  // Word 0 in the low bits

  // Bits 11..5 all zero select the control region
  localparam logic [31:0] ctrlRegionBits = 32'h0000_0FE0;
  localparam int portalSelBit = 12;

  localparam logic [4:0] offInterruptStatus = 5'd0;
  localparam logic [4:0] offInterruptEnable = 5'd4;
  localparam logic [4:0] offNumTiles        = 5'd8;
  localparam logic [4:0] offIndQueueStatus  = 5'd12;
  localparam logic [4:0] offPortalId        = 5'd16;
  localparam logic [4:0] offNumPortals      = 5'd20;

  localparam logic [31:0] fillerWord  = 32'h005A_05A0;
  localparam logic [31:0] reqPortalId = 32'd5;
  localparam logic [31:0] indPortalId = 32'd6;
  localparam logic [31:0] numPortals  = 32'd2;
  localparam logic [31:0] numTiles    = 32'd1;

endpackage

// ==== rtl/portalReadPath.sv ====
`timescale 1ns/100ps

module portalReadPath #(
  parameter int fifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                arValid,
  input  portalPkg::addrChanT ar,
  output logic                arReady,
  output logic                rValid,
  output portalPkg::rDataT    r,
  input  logic                rReady,
  input  logic [31:0]         indWord,
  input  logic [15:0]         indRemain,
  input  logic                reqNotFull,
  input  logic                intrEnable,
  output logic                drain
);
  import portalPkg::*;

  beatT beat;
  rDataT rEntry;
  logic beatValid, rqReady, serve;
  logic indPending;
  logic [31:0] ctrlWord, dataWord;

  burstExpander #(.fifoDepth(fifoDepth)) expander (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .reqValid  (arValid),
    .req       (ar),
    .reqReady  (arReady),
    .beatValid (beatValid),
    .beat      (beat),
    .beatReady (rqReady)
  );

  assign indPending = indRemain != 16'd0;
  assign serve      = beatValid && rqReady;   // One beat per free R slot
  assign drain      = serve && !beat.isCtrl && beat.offset == 5'd0 && indPending;

  always_comb begin
    case (beat.offset)
      // Raw pending, not masked by the enable
      offInterruptStatus: ctrlWord = {31'd0, indPending};
      offNumTiles:        ctrlWord = numTiles;
      offIndQueueStatus:  ctrlWord = {16'd0, indRemain};
      offPortalId:        ctrlWord = beat.portalSel ? indPortalId : reqPortalId;
      offNumPortals:      ctrlWord = numPortals;
      default:            ctrlWord = fillerWord;
    endcase
  end

  always_comb begin
    dataWord = '0;
    if (beat.offset == 5'd0) dataWord = indWord;
    else if (beat.offset == 5'd4) dataWord = {31'd0, reqNotFull};
  end

  assign rEntry = '{data: beat.isCtrl ? ctrlWord : dataWord, id: beat.id, last: beat.last};

  syncFifo #(.fifoDepth(fifoDepth), .width($bits(rDataT))) rQueue (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (beatValid),
    .inData   (rEntry),
    .inReady  (rqReady),
    .outValid (rValid),
    .outData  (r),
    .outReady (rReady)
  );

endmodule

// ==== rtl/portalTop.sv ====
`timescale 1ns/100ps

module portalTop #(
  parameter int fifoDepth = 2,
  parameter int msgWords  = 4
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                arValid,
  input  portalPkg::addrChanT ar,
  output logic                arReady,
  output logic                rValid,
  output portalPkg::rDataT    r,
  input  logic                rReady,
  input  logic                awValid,
  input  portalPkg::addrChanT aw,
  output logic                awReady,
  input  logic                wValid,
  input  logic [31:0]         wData,
  input  logic                wLast,
  output logic                wReady,
  output logic                bValid,
  output portalPkg::bRespT    b,
  input  logic                bReady,
  output logic                reqValid,
  output portalPkg::msgT      reqMsg,
  input  logic                reqReady,
  input  logic                indValid,
  input  portalPkg::msgT      indMsg,
  output logic                indReady,
  output logic                irq
);
  logic push, complete, drain, reqNotFull, intrEnable;
  logic [31:0] pushWord, indWord;
  logic [15:0] indRemain;

  portalReadPath #(.fifoDepth(fifoDepth)) readPath (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .arValid    (arValid),
    .ar         (ar),
    .arReady    (arReady),
    .rValid     (rValid),
    .r          (r),
    .rReady     (rReady),
    .indWord    (indWord),
    .indRemain  (indRemain),
    .reqNotFull (reqNotFull),
    .intrEnable (intrEnable),
    .drain      (drain)
  );

  portalWritePath #(.fifoDepth(fifoDepth)) writePath (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .awValid    (awValid),
    .aw         (aw),
    .awReady    (awReady),
    .wValid     (wValid),
    .wData      (wData),
    .wLast      (wLast),
    .wReady     (wReady),
    .bValid     (bValid),
    .b          (b),
    .bReady     (bReady),
    .reqNotFull (reqNotFull),
    .push       (push),
    .pushWord   (pushWord),
    .complete   (complete),
    .intrEnable (intrEnable)
  );

  messageBuffers #(.msgWords(msgWords)) buffers (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .push       (push),
    .pushWord   (pushWord),
    .complete   (complete),
    .reqValid   (reqValid),
    .reqMsg     (reqMsg),
    .reqReady   (reqReady),
    .reqNotFull (reqNotFull),
    .indValid   (indValid),
    .indMsg     (indMsg),
    .indReady   (indReady),
    .drain      (drain),
    .indWord    (indWord),
    .indRemain  (indRemain)
  );

  assign irq = indRemain != 16'd0 && intrEnable;  // Pending indication words

endmodule

// ==== rtl/portalWritePath.sv ====
`timescale 1ns/100ps

module portalWritePath #(
  parameter int fifoDepth = 2
) (
  input  logic                CLK,
  input  logic                RST_N,
  input  logic                awValid,
  input  portalPkg::addrChanT aw,
  output logic                awReady,
  input  logic                wValid,
  input  logic [31:0]         wData,
  input  logic                wLast,
  output logic                wReady,
  output logic                bValid,
  output portalPkg::bRespT    b,
  input  logic                bReady,
  input  logic                reqNotFull,
  output logic                push,
  output logic [31:0]         pushWord,
  output logic                complete,
  output logic                intrEnable
);
  import portalPkg::*;

  beatT beat;
  bRespT bEntry;
  logic beatValid, expReady, wFifoReady, wHeadValid, bFifoReady;
  logic [31:0] wHead;
  logic completes, retire;
  logic [2:0] openBursts;     // Addresses seen whose last data is still due
  logic wOpen;

  burstExpander #(.fifoDepth(fifoDepth)) expander (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .reqValid  (awValid && openBursts != 3'd7),
    .req       (aw),
    .reqReady  (expReady),
    .beatValid (beatValid),
    .beat      (beat),
    .beatReady (retire)
  );

  assign awReady = expReady && openBursts != 3'd7;
  assign wOpen   = openBursts != 3'd0;
  assign wReady  = wFifoReady && wOpen;

  always_ff @(posedge CLK) begin
    if (!RST_N) openBursts <= '0;
    else openBursts <= openBursts + 3'(awValid && awReady) - 3'(wValid && wReady && wLast);
  end

  syncFifo #(.fifoDepth(fifoDepth), .width(32)) wQueue (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (wValid && wOpen),
    .inData   (wData),
    .inReady  (wFifoReady),
    .outValid (wHeadValid),
    .outData  (wHead),
    .outReady (retire)
  );

  // Nonzero data offset hands the message to the core
  assign completes = !beat.isCtrl && beat.offset != 5'd0;
  assign retire    = beatValid && wHeadValid && (!beat.last || bFifoReady)
                     && (!completes || reqNotFull);
  assign push      = retire && !beat.isCtrl;
  assign pushWord  = wHead;
  assign complete  = push && completes;
  assign bEntry    = '{id: beat.id};

  always_ff @(posedge CLK) begin
    if (!RST_N) intrEnable <= 1'b0;
    else if (retire && beat.isCtrl && beat.offset == offInterruptEnable) intrEnable <= wHead[0];
  end

  syncFifo #(.fifoDepth(fifoDepth), .width($bits(bRespT))) bQueue (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .inValid  (retire && beat.last),
    .inData   (bEntry),
    .inReady  (bFifoReady),
    .outValid (bValid),
    .outData  (b),
    .outReady (bReady)
  );

endmodule

// ==== rtl/syncFifo.sv ====
`timescale 1ns/100ps

module syncFifo #(
  parameter int fifoDepth = 2,
  parameter int width     = 8
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             inValid,
  input  logic [width-1:0] inData,
  output logic             inReady,
  output logic             outValid,
  output logic [width-1:0] outData,
  input  logic             outReady
);
  localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;

  logic [width-1:0] mem [fifoDepth];
  logic [ptrW-1:0] wrPtr, rdPtr;
  logic [ptrW:0] count;
  logic wrEn, rdEn;

  function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
    nextPtr = (p == ptrW'(fifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign inReady  = count != (ptrW + 1)'(fifoDepth);
  assign outValid = count != '0;
  assign outData  = mem[rdPtr];
  assign wrEn     = inValid && inReady;
  assign rdEn     = outValid && outReady;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (wrEn) wrPtr <= nextPtr(wrPtr);
      if (rdEn) rdPtr <= nextPtr(rdPtr);
      if (wrEn != rdEn) count <= wrEn ? count + 1'b1 : count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (wrEn) mem[wrPtr] <= inData;
  end

endmodule

// ==== verilog.f ====
rtl/portalPkg.sv
rtl/syncFifo.sv
rtl/burstExpander.sv
rtl/portalReadPath.sv
rtl/portalWritePath.sv
rtl/messageBuffers.sv
rtl/portalTop.sv
dv/portalTb.sv
